// File: rtl/mem_port_pkg.sv
package mem_port_pkg;

	// Number of clients that share the memory port
	localparam int NUM_CLIENTS = 4;

	// Word address into the single bank, which also sets the bank depth
	localparam int ADDR_WIDTH = 8;
	localparam int BANK_WORDS = 2 ** ADDR_WIDTH;

	// Width of one data word in the bank
	localparam int DATA_WIDTH = 32;

	// Each client owns a small command FIFO of this many entries
	localparam int QUEUE_DEPTH = 4;

	// Pointer width walks the FIFO slots, count width must also hold a full queue
	localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

	// Index of a client, carried with a read so the response can be steered back
	localparam int CLIENT_ID_WIDTH = 2;

	// Kind of command held in a queue entry and sent to the bank
	typedef enum logic
	{
		CMD_READ = 1'b0,
		CMD_WRITE = 1'b1
	} mem_op_t;

endpackage

// File: rtl/arbiter.sv
// Round robin arbiter with a one-hot priority pointer
// The grant is combinational and valid in the same cycle as the request
module arbiter
#(
	parameter int NUM_ENTRIES = 4
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic [NUM_ENTRIES-1:0] request,
	input  logic                   update_lru,
	output logic [NUM_ENTRIES-1:0] grant_oh
);

	// One bit set, marking the requester that is looked at first
	logic [NUM_ENTRIES-1:0] priority_oh;
	logic [NUM_ENTRIES-1:0] priority_nxt;

	// Walk the ring from the priority position and take the first request found
	always_comb
	begin
		logic found;
		int slot;

		found = 1'b0;
		slot = 0;
		grant_oh = '0;
		for (int start = 0; start < NUM_ENTRIES; start++)
		begin
			if (priority_oh[start])
			begin
				for (int step = 0; step < NUM_ENTRIES; step++)
				begin
					slot = (start + step) % NUM_ENTRIES;
					if (!found && request[slot])
					begin
						grant_oh[slot] = 1'b1;
						found = 1'b1;
					end
				end
			end
		end
	end

	// Next priority sits one place past the winner, so the winner goes last next time
	assign priority_nxt = {grant_oh[NUM_ENTRIES-2:0], grant_oh[NUM_ENTRIES-1]};

	// Priority only moves on a cycle where the grant was really used
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_oh <= NUM_ENTRIES'(1);
		else if (update_lru && request != '0)
			priority_oh <= priority_nxt;
	end

	// At most one winner, and somebody always wins while anyone is asking
	assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_oh) && (request == '0 || grant_oh != '0))
	else
		$error("arbiter grant %b not valid for request %b", grant_oh, request);

endmodule

// File: rtl/request_queue.sv
// Per-client command FIFO
// A command written on an edge is visible at the head right after that edge
module request_queue
(
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              enqueue,
	input  mem_port_pkg::mem_op_t             op_in,
	input  logic [mem_port_pkg::ADDR_WIDTH-1:0] addr_in,
	input  logic [mem_port_pkg::DATA_WIDTH-1:0] wdata_in,
	input  logic                              dequeue,
	output mem_port_pkg::mem_op_t             op_out,
	output logic [mem_port_pkg::ADDR_WIDTH-1:0] addr_out,
	output logic [mem_port_pkg::DATA_WIDTH-1:0] wdata_out,
	output logic                              not_empty,
	output logic                              full
);

	import mem_port_pkg::*;

	// Entry storage, split by field
	mem_op_t op_store [QUEUE_DEPTH];
	logic [ADDR_WIDTH-1:0] addr_store [QUEUE_DEPTH];
	logic [DATA_WIDTH-1:0] wdata_store [QUEUE_DEPTH];

	logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
	logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
	logic [QUEUE_COUNT_WIDTH-1:0] count;
	logic push;
	logic pop;

	// A stray strobe against the wrong level is dropped so the pointers stay sane
	assign push = enqueue && !full;
	assign pop = dequeue && not_empty;

	assign not_empty = count != '0;
	assign full = count == QUEUE_COUNT_WIDTH'(QUEUE_DEPTH);

	// The head entry is always presented, valid only while not_empty is high
	assign op_out = op_store[rd_ptr];
	assign addr_out = addr_store[rd_ptr];
	assign wdata_out = wdata_store[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			op_store[wr_ptr] <= op_in;
			addr_store[wr_ptr] <= addr_in;
			wdata_store[wr_ptr] <= wdata_in;
		end
	end

	// Pointers wrap at the last slot; the depth need not be a power of two
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
			begin
				if (wr_ptr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop)
			begin
				if (rd_ptr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Push and pop together leave the count where it was
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			count <= '0;
		else
		begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The client has to watch full before it pushes
	assert property (@(posedge clk) disable iff (reset) full |-> !enqueue)
	else
		$error("request_queue enqueue while full");

	// The arbiter must never pick a queue that has nothing in it
	assert property (@(posedge clk) disable iff (reset) !not_empty |-> !dequeue)
	else
		$error("request_queue dequeue while empty");

endmodule

// File: rtl/sram_bank.sv
// Single-port memory bank
// Writes land on the edge, reads come back registered one cycle later with
// the id of the client that asked
module sram_bank
(
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   cmd_valid,
	input  mem_port_pkg::mem_op_t                  cmd_op,
	input  logic [mem_port_pkg::ADDR_WIDTH-1:0]      cmd_addr,
	input  logic [mem_port_pkg::DATA_WIDTH-1:0]      cmd_wdata,
	input  logic [mem_port_pkg::CLIENT_ID_WIDTH-1:0] cmd_client,
	output logic                                   read_valid,
	output logic [mem_port_pkg::CLIENT_ID_WIDTH-1:0] read_client,
	output logic [mem_port_pkg::DATA_WIDTH-1:0]      read_data
);

	import mem_port_pkg::*;

	logic [DATA_WIDTH-1:0] mem [BANK_WORDS];
	logic do_read;
	logic do_write;

	assign do_read = cmd_valid && cmd_op == CMD_READ;
	assign do_write = cmd_valid && cmd_op == CMD_WRITE;

	// Storage and the read data path
	// Only one command per cycle, so a read never races a write here
	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[cmd_addr] <= cmd_wdata;
		if (do_read)
		begin
			read_data <= mem[cmd_addr];
			read_client <= cmd_client;
		end
	end

	// The valid pulse lasts one cycle per read
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			read_valid <= 1'b0;
		else
			read_valid <= do_read;
	end

	// Each cycle of read_valid must come from a read issued the cycle before,
	// and the tag has to match that read's client
	assert property (@(posedge clk) disable iff (reset)
		read_valid |-> $past(do_read) && read_client == $past(cmd_client))
	else
		$error("sram_bank read_valid without a matching read");

	// A write followed by a read of the same word returns the written data
	assert property (@(posedge clk) disable iff (reset)
		do_write ##1 (do_read && cmd_addr == $past(cmd_addr))
		|=> read_data == $past(cmd_wdata, 2))
	else
		$error("sram_bank read after write returned stale data");

endmodule

// File: rtl/mem_port_top.sv
// Four-client shared memory port
// Each client has its own queue, a round robin arbiter picks one head per cycle,
// and the winner goes to a single bank
module mem_port_top
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 stall,
	input  logic [mem_port_pkg::NUM_CLIENTS-1:0]   enqueue,
	input  mem_port_pkg::mem_op_t                op_in [mem_port_pkg::NUM_CLIENTS],
	input  logic [mem_port_pkg::ADDR_WIDTH-1:0]    addr_in [mem_port_pkg::NUM_CLIENTS],
	input  logic [mem_port_pkg::DATA_WIDTH-1:0]    wdata_in [mem_port_pkg::NUM_CLIENTS],
	output logic [mem_port_pkg::NUM_CLIENTS-1:0]   queue_full,
	output logic [mem_port_pkg::NUM_CLIENTS-1:0]   resp_valid,
	output logic [mem_port_pkg::DATA_WIDTH-1:0]    resp_data
);

	import mem_port_pkg::*;

	// Head of each queue
	mem_op_t head_op [NUM_CLIENTS];
	logic [ADDR_WIDTH-1:0] head_addr [NUM_CLIENTS];
	logic [DATA_WIDTH-1:0] head_wdata [NUM_CLIENTS];
	logic [NUM_CLIENTS-1:0] queue_not_empty;

	logic [NUM_CLIENTS-1:0] grant_oh;
	logic [NUM_CLIENTS-1:0] issue;
	logic [CLIENT_ID_WIDTH-1:0] grant_idx;

	// Command toward the bank
	logic cmd_valid;
	mem_op_t cmd_op;
	logic [ADDR_WIDTH-1:0] cmd_addr;
	logic [DATA_WIDTH-1:0] cmd_wdata;

	// Response from the bank
	logic read_valid;
	logic [CLIENT_ID_WIDTH-1:0] read_client;
	logic [DATA_WIDTH-1:0] read_data;

	genvar c;

	generate
		for (c = 0; c < NUM_CLIENTS; c++)
		begin : g_queue
			request_queue i_request_queue (
				.clk(clk),
				.reset(reset),
				.enqueue(enqueue[c]),
				.op_in(op_in[c]),
				.addr_in(addr_in[c]),
				.wdata_in(wdata_in[c]),
				.dequeue(issue[c]),
				.op_out(head_op[c]),
				.addr_out(head_addr[c]),
				.wdata_out(head_wdata[c]),
				.not_empty(queue_not_empty[c]),
				.full(queue_full[c])
			);
		end
	endgenerate

	arbiter #(
		.NUM_ENTRIES(NUM_CLIENTS)
	) i_arbiter (
		.clk(clk),
		.reset(reset),
		.request(queue_not_empty),
		.update_lru(|issue),
		.grant_oh(grant_oh)
	);

	// Stall masks the grant, so nothing leaves a queue and priority holds
	assign issue = grant_oh & ~{NUM_CLIENTS{stall}};

	// One-hot grant to client index, OR of the indices works since one bit is set
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < NUM_CLIENTS; i++)
		begin
			if (grant_oh[i])
				grant_idx = grant_idx | CLIENT_ID_WIDTH'(i);
		end
	end

	// Head multiplexer
	assign cmd_valid = |issue;
	assign cmd_op = head_op[grant_idx];
	assign cmd_addr = head_addr[grant_idx];
	assign cmd_wdata = head_wdata[grant_idx];

	sram_bank i_sram_bank (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata),
		.cmd_client(grant_idx),
		.read_valid(read_valid),
		.read_client(read_client),
		.read_data(read_data)
	);

	// Response fan-out, the strobe names the client and the data bus is shared
	generate
		for (c = 0; c < NUM_CLIENTS; c++)
		begin : g_resp
			assign resp_valid[c] = read_valid && read_client == CLIENT_ID_WIDTH'(c);
		end
	endgenerate

	assign resp_data = read_data;

	// A read that leaves a queue is answered to the same client on the next cycle
	assert property (@(posedge clk) disable iff (reset)
		cmd_valid && cmd_op == CMD_READ |=> resp_valid == $past(issue))
	else
		$error("mem_port_top read response went to the wrong client");

endmodule

// File: sim/mem_port_tb.sv
module mem_port_tb;

	import mem_port_pkg::*;

	// A queued command is kept in the model as {op, addr, wdata}
	localparam int CMD_WIDTH = 1 + ADDR_WIDTH + DATA_WIDTH;
	localparam int WAIT_LIMIT = 200;
	// Traffic stays inside a small window so reads keep hitting written words
	localparam int TEST_ADDRS = 16;

	logic clk;
	logic reset;
	logic stall;
	logic [NUM_CLIENTS-1:0] enqueue;
	mem_op_t op_in [NUM_CLIENTS];
	logic [ADDR_WIDTH-1:0] addr_in [NUM_CLIENTS];
	logic [DATA_WIDTH-1:0] wdata_in [NUM_CLIENTS];
	logic [NUM_CLIENTS-1:0] queue_full;
	logic [NUM_CLIENTS-1:0] resp_valid;
	logic [DATA_WIDTH-1:0] resp_data;

	// Commands staged by the stimulus for the next push
	mem_op_t next_op [NUM_CLIENTS];
	logic [ADDR_WIDTH-1:0] next_addr [NUM_CLIENTS];
	logic [DATA_WIDTH-1:0] next_wdata [NUM_CLIENTS];

	// Reference model of the per-client queues, the memory words and the priority pointer
	logic [CMD_WIDTH-1:0] model_queue [NUM_CLIENTS][$];
	logic [DATA_WIDTH-1:0] model_mem [BANK_WORDS];
	int model_prio;
	logic [NUM_CLIENTS-1:0] exp_resp_valid;
	logic [DATA_WIDTH-1:0] exp_resp_data;
	logic [NUM_CLIENTS-1:0] exp_full;
	logic model_idle;
	logic enq_seen;
	string test_name;

	mem_port_top i_mem_port_top (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.enqueue(enqueue),
		.op_in(op_in),
		.addr_in(addr_in),
		.wdata_in(wdata_in),
		.queue_full(queue_full),
		.resp_valid(resp_valid),
		.resp_data(resp_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	task automatic report_mismatch(input string check, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("CHECK FAILED %s in test %s: expected %0h, actual %0h",
			check, test_name, expected, actual);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic abort_run(input string why);
		$display("ERROR in test %s: %s", test_name, why);
		$display("TESTS FAILED");
		$fatal(1, "stopped on a timeout");
	endtask

	// First client with work, searching the ring from the modeled priority
	function automatic int find_winner();
		int slot;

		for (int step = 0; step < NUM_CLIENTS; step++)
		begin
			slot = (model_prio + step) % NUM_CLIENTS;
			if (model_queue[slot].size() != 0)
				return slot;
		end
		return -1;
	endfunction

	// The model sees the same pre-edge inputs the DUT samples on this edge
	always @(posedge clk, posedge reset)
	begin
		logic [CMD_WIDTH-1:0] cmd;
		logic [NUM_CLIENTS-1:0] full_now;
		int slot;
		bit issued;
		bit pending;

		if (reset)
		begin
			model_prio = 0;
			for (int c = 0; c < NUM_CLIENTS; c++)
				model_queue[c].delete();
			exp_resp_valid <= '0;
			exp_full <= '0;
			model_idle <= 1'b1;
			enq_seen <= 1'b0;
		end
		else
		begin
			slot = find_winner();
			issued = slot >= 0 && !stall;
			exp_resp_valid <= '0;
			if (issued)
			begin
				cmd = model_queue[slot].pop_front();
				// The winner drops to last place for the next pick
				model_prio = (slot + 1) % NUM_CLIENTS;
				if (mem_op_t'(cmd[CMD_WIDTH-1]) == CMD_WRITE)
					model_mem[cmd[DATA_WIDTH +: ADDR_WIDTH]] = cmd[DATA_WIDTH-1:0];
				else
				begin
					exp_resp_valid <= NUM_CLIENTS'(1 << slot);
					exp_resp_data <= model_mem[cmd[DATA_WIDTH +: ADDR_WIDTH]];
				end
			end
			// New commands land behind whatever the queue already holds
			pending = 1'b0;
			for (int c = 0; c < NUM_CLIENTS; c++)
			begin
				if (enqueue[c])
					model_queue[c].push_back({op_in[c], addr_in[c], wdata_in[c]});
				full_now[c] = model_queue[c].size() == QUEUE_DEPTH;
				pending = pending || model_queue[c].size() != 0;
			end
			exp_full <= full_now;
			model_idle <= !pending && !issued;
			enq_seen <= enq_seen || enqueue != '0;
		end
	end

	// Strobe names exactly the client the model issued a read for, one cycle late
	assert property (@(posedge clk) disable iff (reset) resp_valid == exp_resp_valid)
	else
		report_mismatch("resp_valid", 64'($sampled(exp_resp_valid)), 64'($sampled(resp_valid)));

	assert property (@(posedge clk) disable iff (reset)
		exp_resp_valid != '0 |-> resp_data == exp_resp_data)
	else
		report_mismatch("resp_data", 64'($sampled(exp_resp_data)), 64'($sampled(resp_data)));

	assert property (@(posedge clk) disable iff (reset) queue_full == exp_full)
	else
		report_mismatch("queue_full", 64'($sampled(exp_full)), 64'($sampled(queue_full)));

	// Nothing leaves a queue under stall, so no response follows a stalled cycle
	assert property (@(posedge clk) disable iff (reset) stall |=> resp_valid == '0)
	else
		report_mismatch("stall_quiet", 64'(0), 64'($sampled(resp_valid)));

	assert property (@(posedge clk) disable iff (reset)
		!enq_seen |-> resp_valid == '0 && queue_full == '0)
	else
		report_mismatch("reset_quiet", 64'(0), 64'({$sampled(resp_valid), $sampled(queue_full)}));

	// Push the staged commands for every client in mask, one strobe cycle
	task automatic push_cmds(input logic [NUM_CLIENTS-1:0] mask);
		int waited;

		waited = 0;
		@(posedge clk);
		while ((queue_full & mask) != '0)
		begin
			if (waited == WAIT_LIMIT)
				abort_run("a queue stayed full while a push was waiting");
			waited++;
			@(posedge clk);
		end
		for (int c = 0; c < NUM_CLIENTS; c++)
		begin
			op_in[c] <= next_op[c];
			addr_in[c] <= next_addr[c];
			wdata_in[c] <= next_wdata[c];
		end
		enqueue <= mask;
		@(posedge clk);
		enqueue <= '0;
	endtask

	task automatic stage_random(input bit read_only);
		for (int c = 0; c < NUM_CLIENTS; c++)
		begin
			next_op[c] = (read_only || $urandom_range(0, 1) == 0) ? CMD_READ : CMD_WRITE;
			next_addr[c] = ADDR_WIDTH'($urandom_range(0, TEST_ADDRS - 1));
			next_wdata[c] = $urandom();
		end
	endtask

	task automatic wait_idle();
		int waited;

		waited = 0;
		@(posedge clk);
		while (!model_idle)
		begin
			if (waited == WAIT_LIMIT)
				abort_run("queued commands were never all served");
			waited++;
			@(posedge clk);
		end
	endtask

	task automatic wait_full(input logic [NUM_CLIENTS-1:0] mask);
		int waited;

		waited = 0;
		@(posedge clk);
		while ((queue_full & mask) != mask)
		begin
			if (waited == WAIT_LIMIT)
				abort_run("queue_full never rose after the queue was filled");
			waited++;
			@(posedge clk);
		end
	endtask

	initial
	begin
		void'($urandom(32'h3805_2918));
		test_name = "reset_quiet";
		reset = 1'b1;
		stall = 1'b0;
		enqueue = '0;
		for (int c = 0; c < NUM_CLIENTS; c++)
		begin
			op_in[c] = CMD_READ;
			addr_in[c] = '0;
			wdata_in[c] = '0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (3) @(posedge clk);

		// Every word in the traffic window gets written before anyone reads it
		test_name = "write_fill";
		for (int round = 0; round < 4; round++)
		begin
			for (int c = 0; c < NUM_CLIENTS; c++)
			begin
				next_op[c] = CMD_WRITE;
				next_addr[c] = ADDR_WIDTH'(c * 4 + round);
				next_wdata[c] = $urandom();
			end
			push_cmds('1);
		end
		wait_idle();

		test_name = "mixed_traffic";
		for (int round = 0; round < 24; round++)
		begin
			stage_random(1'b0);
			push_cmds(NUM_CLIENTS'($urandom_range(1, 15)));
		end
		wait_idle();

		// All four queues loaded under stall, then drained in rotating order
		test_name = "round_robin";
		@(posedge clk);
		stall <= 1'b1;
		for (int round = 0; round < QUEUE_DEPTH; round++)
		begin
			stage_random(1'b1);
			push_cmds('1);
		end
		wait_full('1);
		stall <= 1'b0;
		wait_idle();

		test_name = "stall_fill";
		@(posedge clk);
		stall <= 1'b1;
		for (int round = 0; round < QUEUE_DEPTH; round++)
		begin
			stage_random(1'b1);
			push_cmds(4'b0100);
		end
		wait_full(4'b0100);
		// Hold the stall a while so the no-response check gets exercised
		repeat (4) @(posedge clk);
		stall <= 1'b0;
		wait_idle();

		// A lone requester wins on every cycle it has something queued
		test_name = "single_client";
		for (int round = 0; round < 6; round++)
		begin
			stage_random(1'b1);
			push_cmds(4'b1000);
		end
		wait_idle();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: vlog.f
rtl/mem_port_pkg.sv
rtl/arbiter.sv
rtl/request_queue.sv
rtl/sram_bank.sv
rtl/mem_port_top.sv
sim/mem_port_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the memory port testbench with Verilator and run it
# The exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mem_port_tb \
	-f vlog.f \
	-o mem_port_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/mem_port_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished with status 0"
exit 0
